// File: hw/eth_types_pkg.sv
// Ethernet frame field types for the two-port frame mux.
// Shared by the header and payload datapath and by the testbench that drives it.
// Import where MAC addresses, ethertypes, payload bytes or port numbers are declared.
package eth_types_pkg;

    localparam int MAC_ADDR_W = 48;
    localparam int ETH_TYPE_W = 16;
    localparam int ETH_BYTE_W = 8;
    localparam int PORT_SEL_W = 1;

    // destination or source station address
    typedef logic [MAC_ADDR_W-1:0] mac_addr_t;

    // ethertype / length field of the header beat
    typedef logic [ETH_TYPE_W-1:0] eth_type_t;

    // one byte of the payload stream
    typedef logic [ETH_BYTE_W-1:0] eth_byte_t;

    // input port number, two ports only
    typedef logic [PORT_SEL_W-1:0] port_sel_t;

endpackage

// File: hw/mux_csr_pkg.sv
// Register map and bus widths of the mux control port.
// Used by the Wishbone slave and by the bus model in the testbench.
package mux_csr_pkg;

    localparam int CSR_ADDR_W  = 4;
    localparam int CSR_DATA_W  = 32;
    localparam int FRAME_CNT_W = 16;

    typedef logic [CSR_ADDR_W-1:0]  wb_addr_t;
    typedef logic [CSR_DATA_W-1:0]  wb_data_t;
    typedef logic [FRAME_CNT_W-1:0] frame_cnt_t;

    // bit 0 enable, bit 1 select
    localparam wb_addr_t CSR_CTRL = 4'h0;
    // frame counters, read only, any write clears
    localparam wb_addr_t CSR_CNT0 = 4'h4;
    localparam wb_addr_t CSR_CNT1 = 4'h8;

endpackage

// File: hw/eth_payload_skid.sv
// Two-entry skid buffer on the byte-wide payload stream.
// Registers data, valid, last and user toward the output and gives the source an
// early ready one cycle ahead, so out_tready never reaches the input combinationally.
// The source must only present a byte when its registered copy of the early ready is high.
`timescale 1ns/100ps

module eth_payload_skid (
    input  logic                     clk,
    input  logic                     rst,
    input  eth_types_pkg::eth_byte_t int_tdata,
    input  logic                     int_tvalid,
    input  logic                     int_tlast,
    input  logic                     int_tuser,
    output logic                     int_ready_early,
    output eth_types_pkg::eth_byte_t out_tdata,
    output logic                     out_tvalid,
    input  logic                     out_tready,
    output logic                     out_tlast,
    output logic                     out_tuser
);
    import eth_types_pkg::*;

    eth_byte_t tmp_data_q;
    logic      tmp_last_q;
    logic      tmp_user_q;
    logic      tmp_valid_q;
    logic      tmp_valid_d;
    logic      out_valid_d;
    logic      in_ready_q;
    logic      load_out_from_in;
    logic      load_out_from_tmp;
    logic      load_tmp_from_in;

    // ready next cycle unless a stalled output byte plus a new one would fill the spare slot
    assign int_ready_early = out_tready | (~tmp_valid_q & (~out_tvalid | ~int_tvalid));

    always_comb begin
        out_valid_d       = out_tvalid;
        tmp_valid_d       = tmp_valid_q;
        load_out_from_in  = 1'b0;
        load_out_from_tmp = 1'b0;
        load_tmp_from_in  = 1'b0;
        if (in_ready_q) begin
            if (out_tready | ~out_tvalid) begin
                out_valid_d      = int_tvalid;
                load_out_from_in = 1'b1;
            end else begin
                // output stalled, park the byte
                tmp_valid_d      = int_tvalid;
                load_tmp_from_in = 1'b1;
            end
        end else if (out_tready) begin
            out_valid_d       = tmp_valid_q;
            tmp_valid_d       = 1'b0;
            load_out_from_tmp = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_tvalid  <= 1'b0;
            tmp_valid_q <= 1'b0;
            in_ready_q  <= 1'b0;
        end else begin
            out_tvalid  <= out_valid_d;
            tmp_valid_q <= tmp_valid_d;
            in_ready_q  <= int_ready_early;
        end
    end

    always_ff @(posedge clk) begin
        if (load_out_from_in) begin
            out_tdata <= int_tdata;
            out_tlast <= int_tlast;
            out_tuser <= int_tuser;
        end else if (load_out_from_tmp) begin
            out_tdata <= tmp_data_q;
            out_tlast <= tmp_last_q;
            out_tuser <= tmp_user_q;
        end
        if (load_tmp_from_in) begin
            tmp_data_q <= int_tdata;
            tmp_last_q <= int_tlast;
            tmp_user_q <= int_tuser;
        end
    end

endmodule

// File: hw/eth_mux_2.sv
// Frame-aware two-input Ethernet multiplexer.
// Takes a header from the port given by select while enabled and idle, latches that
// port for the whole frame and steers its payload onto the internal stream until tlast.
// Payload goes out through eth_payload_skid, whose early ready drives the input tready.
`timescale 1ns/100ps

module eth_mux_2 (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     enable,
    input  eth_types_pkg::port_sel_t select,
    input  logic                     in0_hdr_valid,
    output logic                     in0_hdr_ready,
    input  eth_types_pkg::mac_addr_t in0_dest_mac,
    input  eth_types_pkg::mac_addr_t in0_src_mac,
    input  eth_types_pkg::eth_type_t in0_eth_type,
    input  eth_types_pkg::eth_byte_t in0_tdata,
    input  logic                     in0_tvalid,
    output logic                     in0_tready,
    input  logic                     in0_tlast,
    input  logic                     in0_tuser,
    input  logic                     in1_hdr_valid,
    output logic                     in1_hdr_ready,
    input  eth_types_pkg::mac_addr_t in1_dest_mac,
    input  eth_types_pkg::mac_addr_t in1_src_mac,
    input  eth_types_pkg::eth_type_t in1_eth_type,
    input  eth_types_pkg::eth_byte_t in1_tdata,
    input  logic                     in1_tvalid,
    output logic                     in1_tready,
    input  logic                     in1_tlast,
    input  logic                     in1_tuser,
    output logic                     out_hdr_valid,
    input  logic                     out_hdr_ready,
    output eth_types_pkg::mac_addr_t out_dest_mac,
    output eth_types_pkg::mac_addr_t out_src_mac,
    output eth_types_pkg::eth_type_t out_eth_type,
    output eth_types_pkg::eth_byte_t int_tdata,
    output logic                     int_tvalid,
    output logic                     int_tlast,
    output logic                     int_tuser,
    input  logic                     int_ready_early,
    output logic                     frame_start,
    output eth_types_pkg::port_sel_t frame_port
);
    import eth_types_pkg::*;

    typedef enum logic {
        ST_IDLE,
        ST_FRAME
    } state_t;

    state_t    state_q;
    state_t    state_d;
    port_sel_t port_q;
    port_sel_t port_d;
    logic      start;

    // header of the port named by select, only looked at while idle
    logic      sel_hdr_valid;
    mac_addr_t sel_dest_mac;
    mac_addr_t sel_src_mac;
    eth_type_t sel_eth_type;

    // payload of the latched port
    eth_byte_t cur_tdata;
    logic      cur_tvalid;
    logic      cur_tready;
    logic      cur_tlast;
    logic      cur_tuser;
    logic      cur_xfer;

    always_comb begin
        if (select == 1'b0) begin
            sel_hdr_valid = in0_hdr_valid;
            sel_dest_mac  = in0_dest_mac;
            sel_src_mac   = in0_src_mac;
            sel_eth_type  = in0_eth_type;
        end else begin
            sel_hdr_valid = in1_hdr_valid;
            sel_dest_mac  = in1_dest_mac;
            sel_src_mac   = in1_src_mac;
            sel_eth_type  = in1_eth_type;
        end
    end

    always_comb begin
        if (port_q == 1'b0) begin
            cur_tdata  = in0_tdata;
            cur_tvalid = in0_tvalid;
            cur_tready = in0_tready;
            cur_tlast  = in0_tlast;
            cur_tuser  = in0_tuser;
        end else begin
            cur_tdata  = in1_tdata;
            cur_tvalid = in1_tvalid;
            cur_tready = in1_tready;
            cur_tlast  = in1_tlast;
            cur_tuser  = in1_tuser;
        end
    end

    assign cur_xfer = (state_q == ST_FRAME) & cur_tvalid & cur_tready;
    // a pending output header blocks the next frame
    assign start = (state_q == ST_IDLE) & enable & ~out_hdr_valid & sel_hdr_valid;

    always_comb begin
        state_d = state_q;
        port_d  = port_q;
        if (state_q == ST_FRAME) begin
            if (cur_xfer & cur_tlast) begin
                state_d = ST_IDLE;
            end
        end else if (start) begin
            state_d = ST_FRAME;
            port_d  = select;
        end
    end

    assign int_tdata  = cur_tdata;
    assign int_tvalid = cur_xfer;
    assign int_tlast  = cur_tlast;
    assign int_tuser  = cur_tuser;
    assign frame_port = port_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q       <= ST_IDLE;
            port_q        <= '0;
            in0_hdr_ready <= 1'b0;
            in1_hdr_ready <= 1'b0;
            in0_tready    <= 1'b0;
            in1_tready    <= 1'b0;
            out_hdr_valid <= 1'b0;
            frame_start   <= 1'b0;
        end else begin
            state_q       <= state_d;
            port_q        <= port_d;
            in0_hdr_ready <= start & (select == 1'b0);
            in1_hdr_ready <= start & (select == 1'b1);
            // tready follows the skid buffer one cycle ahead, on the latched port only
            in0_tready    <= int_ready_early & (state_d == ST_FRAME) & (port_d == 1'b0);
            in1_tready    <= int_ready_early & (state_d == ST_FRAME) & (port_d == 1'b1);
            if (start) begin
                out_hdr_valid <= 1'b1;
            end else if (out_hdr_ready) begin
                out_hdr_valid <= 1'b0;
            end
            frame_start   <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            out_dest_mac <= sel_dest_mac;
            out_src_mac  <= sel_src_mac;
            out_eth_type <= sel_eth_type;
        end
    end

endmodule

// File: hw/eth_mux_csr.sv
// Wishbone classic register block of the frame mux.
// Holds enable and select in CTRL and counts frames started on each port.
// Each request gets a single-cycle registered ack; writes take effect after the ack.
`timescale 1ns/100ps

module eth_mux_csr (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  mux_csr_pkg::wb_addr_t    wb_adr,
    input  mux_csr_pkg::wb_data_t    wb_dat_w,
    output logic                     wb_ack,
    output mux_csr_pkg::wb_data_t    wb_dat_r,
    input  logic                     frame_start,
    input  eth_types_pkg::port_sel_t frame_port,
    output logic                     enable,
    output eth_types_pkg::port_sel_t select
);
    import mux_csr_pkg::*;

    frame_cnt_t cnt0_q;
    frame_cnt_t cnt1_q;
    wb_data_t   rd_data;
    logic       req;
    logic       wr;

    // clear wins over a frame start in the same cycle
    function automatic frame_cnt_t cnt_next(input frame_cnt_t cnt, input logic clr,
                                            input logic inc);
        if (clr) begin
            return '0;
        end
        if (inc && cnt != '1) begin
            return cnt + 1'b1;
        end
        return cnt;
    endfunction

    assign req = wb_cyc & wb_stb;
    // commit in the ack cycle
    assign wr  = req & wb_we & wb_ack;

    always_comb begin
        case (wb_adr)
            CSR_CTRL: rd_data = wb_data_t'({select, enable});
            CSR_CNT0: rd_data = wb_data_t'(cnt0_q);
            CSR_CNT1: rd_data = wb_data_t'(cnt1_q);
            default:  rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= req & ~wb_ack;
        end
    end

    always_ff @(posedge clk) begin
        if (req & ~wb_ack) begin
            wb_dat_r <= rd_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            enable <= 1'b0;
            select <= '0;
            cnt0_q <= '0;
            cnt1_q <= '0;
        end else begin
            if (wr && wb_adr == CSR_CTRL) begin
                enable <= wb_dat_w[0];
                select <= wb_dat_w[1];
            end
            cnt0_q <= cnt_next(cnt0_q, wr && wb_adr == CSR_CNT0,
                               frame_start && frame_port == 1'b0);
            cnt1_q <= cnt_next(cnt1_q, wr && wb_adr == CSR_CNT1,
                               frame_start && frame_port == 1'b1);
        end
    end

endmodule

// File: hw/eth_mux_top.sv
// Top of the two-port Ethernet frame mux.
// Joins the Wishbone register block, the frame mux and the payload skid buffer.
// Ports keep the names of the blocks below, so connections are made by name.
`timescale 1ns/100ps

module eth_mux_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  mux_csr_pkg::wb_addr_t    wb_adr,
    input  mux_csr_pkg::wb_data_t    wb_dat_w,
    output logic                     wb_ack,
    output mux_csr_pkg::wb_data_t    wb_dat_r,
    input  logic                     in0_hdr_valid,
    output logic                     in0_hdr_ready,
    input  eth_types_pkg::mac_addr_t in0_dest_mac,
    input  eth_types_pkg::mac_addr_t in0_src_mac,
    input  eth_types_pkg::eth_type_t in0_eth_type,
    input  eth_types_pkg::eth_byte_t in0_tdata,
    input  logic                     in0_tvalid,
    output logic                     in0_tready,
    input  logic                     in0_tlast,
    input  logic                     in0_tuser,
    input  logic                     in1_hdr_valid,
    output logic                     in1_hdr_ready,
    input  eth_types_pkg::mac_addr_t in1_dest_mac,
    input  eth_types_pkg::mac_addr_t in1_src_mac,
    input  eth_types_pkg::eth_type_t in1_eth_type,
    input  eth_types_pkg::eth_byte_t in1_tdata,
    input  logic                     in1_tvalid,
    output logic                     in1_tready,
    input  logic                     in1_tlast,
    input  logic                     in1_tuser,
    output logic                     out_hdr_valid,
    input  logic                     out_hdr_ready,
    output eth_types_pkg::mac_addr_t out_dest_mac,
    output eth_types_pkg::mac_addr_t out_src_mac,
    output eth_types_pkg::eth_type_t out_eth_type,
    output eth_types_pkg::eth_byte_t out_tdata,
    output logic                     out_tvalid,
    input  logic                     out_tready,
    output logic                     out_tlast,
    output logic                     out_tuser
);
    import eth_types_pkg::*;

    // control from the register block
    logic      enable;
    port_sel_t select;
    logic      frame_start;
    port_sel_t frame_port;

    // mux to skid buffer
    eth_byte_t int_tdata;
    logic      int_tvalid;
    logic      int_tlast;
    logic      int_tuser;
    logic      int_ready_early;

    eth_mux_csr u_csr (.*);

    eth_mux_2 u_mux (.*);

    eth_payload_skid u_skid (.*);

endmodule

// File: verification/clk_gen.sv
// Clock and reset source for the frame mux testbench.
// clk runs with a 4 ns period; rst starts high and drops on a falling edge
// after five rising edges.
`timescale 1ns/100ps

module clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// File: verification/tb_eth_mux.sv
// Directed testbench for the two-port Ethernet frame mux.
// Programs the mux over Wishbone, sends frames on either input and checks the
// forwarded header, payload bytes and frame counters against what was sent.
// All inputs change on the falling edge; outputs are sampled there as well.
`timescale 1ns/100ps

module tb_eth_mux;
    import eth_types_pkg::*;
    import mux_csr_pkg::*;

    localparam int ACK_TIMEOUT   = 20;
    localparam int HDR_TIMEOUT   = 100;
    localparam int BYTE_TIMEOUT  = 100;
    localparam int FRAME_TIMEOUT = 2000;

    logic      clk;
    logic      rst;
    logic      wb_cyc;
    logic      wb_stb;
    logic      wb_we;
    wb_addr_t  wb_adr;
    wb_data_t  wb_dat_w;
    logic      wb_ack;
    wb_data_t  wb_dat_r;
    logic      in0_hdr_valid;
    logic      in0_hdr_ready;
    mac_addr_t in0_dest_mac;
    mac_addr_t in0_src_mac;
    eth_type_t in0_eth_type;
    eth_byte_t in0_tdata;
    logic      in0_tvalid;
    logic      in0_tready;
    logic      in0_tlast;
    logic      in0_tuser;
    logic      in1_hdr_valid;
    logic      in1_hdr_ready;
    mac_addr_t in1_dest_mac;
    mac_addr_t in1_src_mac;
    eth_type_t in1_eth_type;
    eth_byte_t in1_tdata;
    logic      in1_tvalid;
    logic      in1_tready;
    logic      in1_tlast;
    logic      in1_tuser;
    logic      out_hdr_valid;
    logic      out_hdr_ready;
    mac_addr_t out_dest_mac;
    mac_addr_t out_src_mac;
    eth_type_t out_eth_type;
    eth_byte_t out_tdata;
    logic      out_tvalid;
    logic      out_tready;
    logic      out_tlast;
    logic      out_tuser;

    // frame currently being sent and expected at the output
    mac_addr_t tx_dest;
    mac_addr_t tx_src;
    eth_type_t tx_type;
    eth_byte_t tx_data[$];
    logic      tx_user[$];
    int        sent_cnt[2];
    // port 0 header must stay unaccepted while set
    logic      guard_in0;

    clk_gen u_clk_gen (
        .clk(clk),
        .rst(rst)
    );

    eth_mux_top uut (.*);

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input logic [63:0] got,
                            input logic [63:0] exp);
        assert (got === exp) else begin
            abort_run($sformatf("FAIL %s expected 0x%0h got 0x%0h", name, exp, got));
        end
    endtask

    always @(negedge clk) begin
        if (guard_in0) begin
            assert (!in0_hdr_ready) else abort_run("port 0 header taken while port 1 selected");
        end
    end

    task automatic drive_hdr(input port_sel_t port, input logic valid, input mac_addr_t dest,
                             input mac_addr_t src, input eth_type_t etype);
        if (port == 1'b0) begin
            in0_hdr_valid = valid;
            in0_dest_mac  = dest;
            in0_src_mac   = src;
            in0_eth_type  = etype;
        end else begin
            in1_hdr_valid = valid;
            in1_dest_mac  = dest;
            in1_src_mac   = src;
            in1_eth_type  = etype;
        end
    endtask

    task automatic drive_byte(input port_sel_t port, input logic valid, input eth_byte_t data,
                              input logic last, input logic user);
        if (port == 1'b0) begin
            in0_tvalid = valid;
            in0_tdata  = data;
            in0_tlast  = last;
            in0_tuser  = user;
        end else begin
            in1_tvalid = valid;
            in1_tdata  = data;
            in1_tlast  = last;
            in1_tuser  = user;
        end
    endtask

    function automatic logic hdr_ready_of(input port_sel_t port);
        return (port == 1'b0) ? in0_hdr_ready : in1_hdr_ready;
    endfunction

    function automatic logic tready_of(input port_sel_t port);
        return (port == 1'b0) ? in0_tready : in1_tready;
    endfunction

    // one classic cycle held through the ack cycle
    task automatic wb_access(input logic we, input wb_addr_t adr, input wb_data_t wdata,
                             output wb_data_t rdata);
        int n;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            assert (n <= ACK_TIMEOUT) else abort_run("no Wishbone ack within the timeout");
        end while (!wb_ack);
        rdata = wb_dat_r;
        @(negedge clk);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input wb_addr_t adr, input wb_data_t wdata);
        wb_data_t unused;
        wb_access(1'b1, adr, wdata, unused);
    endtask

    task automatic wb_read(input wb_addr_t adr, output wb_data_t rdata);
        wb_access(1'b0, adr, '0, rdata);
    endtask

    task automatic build_frame(input int len);
        tx_dest = mac_addr_t'({$urandom, $urandom});
        tx_src  = mac_addr_t'({$urandom, $urandom});
        tx_type = eth_type_t'($urandom);
        tx_data.delete();
        tx_user.delete();
        for (int i = 0; i < len; i++) begin
            tx_data.push_back(eth_byte_t'($urandom));
            tx_user.push_back(($urandom % 4) == 0);
        end
    endtask

    task automatic send_frame(input port_sel_t port);
        int n;
        drive_hdr(port, 1'b1, tx_dest, tx_src, tx_type);
        n = 0;
        do begin
            @(negedge clk);
            n++;
            assert (n <= HDR_TIMEOUT) else abort_run("input header was never accepted");
        end while (!hdr_ready_of(port));
        @(negedge clk);
        drive_hdr(port, 1'b0, '0, '0, '0);
        foreach (tx_data[i]) begin
            drive_byte(port, 1'b1, tx_data[i], i == tx_data.size() - 1, tx_user[i]);
            n = 0;
            // registered tready holds its value here until the next edge
            while (!tready_of(port)) begin
                @(negedge clk);
                n++;
                assert (n <= BYTE_TIMEOUT) else abort_run("payload byte was never accepted");
            end
            @(negedge clk);
        end
        drive_byte(port, 1'b0, '0, 1'b0, 1'b0);
        sent_cnt[port]++;
    endtask

    task automatic expect_frame(input bit rand_ready);
        eth_byte_t rx_data[$];
        logic      rx_user[$];
        logic      rx_last[$];
        bit        got_hdr;
        bit        done;
        int        n;
        got_hdr = 1'b0;
        done    = 1'b0;
        n       = 0;
        while (!done) begin
            @(negedge clk);
            n++;
            assert (n <= FRAME_TIMEOUT) else abort_run("frame never completed at the output");
            if (!got_hdr && out_hdr_valid) begin
                got_hdr = 1'b1;
                check_eq("out_dest_mac", out_dest_mac, tx_dest);
                check_eq("out_src_mac", out_src_mac, tx_src);
                check_eq("out_eth_type", out_eth_type, tx_type);
            end
            out_tready = rand_ready ? 1'($urandom % 2) : 1'b1;
            if (out_tvalid && out_tready) begin
                rx_data.push_back(out_tdata);
                rx_user.push_back(out_tuser);
                rx_last.push_back(out_tlast);
                done = out_tlast;
            end
        end
        out_tready = 1'b1;
        assert (got_hdr) else abort_run("payload ended before any output header");
        check_eq("payload length", rx_data.size(), tx_data.size());
        foreach (tx_data[i]) begin
            check_eq("out_tdata", rx_data[i], tx_data[i]);
            check_eq("out_tuser", rx_user[i], tx_user[i]);
            check_eq("out_tlast", rx_last[i], i == tx_data.size() - 1);
        end
    endtask

    task automatic run_frame(input port_sel_t port, input int len, input bit rand_ready);
        build_frame(len);
        fork
            send_frame(port);
            expect_frame(rand_ready);
        join
    endtask

    task automatic reset_defaults();
        wb_data_t rdata;
        wb_read(CSR_CTRL, rdata);
        check_eq("CTRL", rdata, 0);
        wb_read(CSR_CNT0, rdata);
        check_eq("CNT0", rdata, 0);
        wb_read(CSR_CNT1, rdata);
        check_eq("CNT1", rdata, 0);
        check_eq("out_hdr_valid", out_hdr_valid, 0);
        check_eq("out_tvalid", out_tvalid, 0);
        check_eq("in0_hdr_ready", in0_hdr_ready, 0);
        check_eq("in1_hdr_ready", in1_hdr_ready, 0);
        // mux still disabled
        drive_hdr(1'b0, 1'b1, 48'h02_00_00_00_00_01, 48'h02_00_00_00_00_02, 16'h0800);
        repeat (50) begin
            @(negedge clk);
            check_eq("in0_hdr_ready", in0_hdr_ready, 0);
        end
        drive_hdr(1'b0, 1'b0, '0, '0, '0);
    endtask

    task automatic port0_forwarding();
        wb_write(CSR_CTRL, 32'h1);
        run_frame(1'b0, 8, 1'b0);
    endtask

    task automatic select_latching();
        wb_write(CSR_CTRL, 32'h3);
        drive_hdr(1'b0, 1'b1, 48'h0a_0b_0c_0d_0e_0f, 48'h01_02_03_04_05_06, 16'h86dd);
        guard_in0 = 1'b1;
        run_frame(1'b1, 12, 1'b0);
        drive_hdr(1'b0, 1'b0, '0, '0, '0);
        guard_in0 = 1'b0;
        // select flips back to port 0 part way through this frame
        build_frame(16);
        fork
            send_frame(1'b1);
            expect_frame(1'b0);
            begin
                repeat (6) @(negedge clk);
                wb_write(CSR_CTRL, 32'h1);
            end
        join
    endtask

    task automatic random_backpressure();
        run_frame(1'b0, 40, 1'b1);
    endtask

    task automatic frame_counting();
        wb_data_t rdata;
        wb_write(CSR_CTRL, 32'h3);
        run_frame(1'b1, 5, 1'b1);
        run_frame(1'b1, 3, 1'b0);
        wb_write(CSR_CTRL, 32'h1);
        run_frame(1'b0, 6, 1'b0);
        run_frame(1'b0, 1, 1'b1);
        wb_read(CSR_CNT0, rdata);
        check_eq("CNT0", rdata, sent_cnt[0]);
        wb_read(CSR_CNT1, rdata);
        check_eq("CNT1", rdata, sent_cnt[1]);
        wb_write(CSR_CNT0, 32'hffff_ffff);
        wb_read(CSR_CNT0, rdata);
        check_eq("CNT0", rdata, 0);
        wb_read(CSR_CNT1, rdata);
        check_eq("CNT1", rdata, sent_cnt[1]);
    endtask

    task automatic init_inputs();
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        drive_hdr(1'b0, 1'b0, '0, '0, '0);
        drive_hdr(1'b1, 1'b0, '0, '0, '0);
        drive_byte(1'b0, 1'b0, '0, 1'b0, 1'b0);
        drive_byte(1'b1, 1'b0, '0, 1'b0, 1'b0);
        out_hdr_ready = 1'b0;
        out_tready    = 1'b0;
        guard_in0     = 1'b0;
        sent_cnt      = '{0, 0};
    endtask

    task automatic wait_reset_done();
        int n;
        n = 0;
        while (rst !== 1'b0) begin
            @(negedge clk);
            n++;
            assert (n < 50) else abort_run("reset was never released");
        end
    endtask

    initial begin
        void'($urandom(85));
        init_inputs();
        wait_reset_done();
        out_hdr_ready = 1'b1;
        out_tready    = 1'b1;
        reset_defaults();
        port0_forwarding();
        select_latching();
        random_backpressure();
        frame_counting();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: sources.f
hw/eth_types_pkg.sv
hw/mux_csr_pkg.sv
hw/eth_payload_skid.sv
hw/eth_mux_2.sv
hw/eth_mux_csr.sv
hw/eth_mux_top.sv
verification/clk_gen.sv
verification/tb_eth_mux.sv

// File: Bender.yml
package:
  name: eth_mux

sources:
  - files:
      - hw/eth_types_pkg.sv
      - hw/mux_csr_pkg.sv
      - hw/eth_payload_skid.sv
      - hw/eth_mux_2.sv
      - hw/eth_mux_csr.sv
      - hw/eth_mux_top.sv
  - target: test
    files:
      - verification/clk_gen.sv
      - verification/tb_eth_mux.sv
